// ==== mipsCore.f ====
verilog/mipsPkg.sv
verilog/instrLatch.sv
verilog/controlUnit.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/dataMemory.sv
verilog/mipsCore.sv
test/resultChecker.sv
test/mipsCoreTb.sv

// ==== test/mipsCases.txt ====
# name noGap instr regWe regWAddr regWData memWe memAddr memWData readData
# all fields hex, noGap 1 strobes the next case in this case's execute cycle
addi_pos 0 20010123 1 01 00000123 0 00000000 00000000 00000000
addi_neg 0 2002fffc 1 02 fffffffc 0 00000000 00000000 00000000
ori_zext 0 34038001 1 03 00008001 0 00000000 00000000 00000000
andi_zext 0 3044f0f0 1 04 0000f0f0 0 00000000 00000000 00000000
addi_reg 0 20257fff 1 05 00008122 0 00000000 00000000 00000000
andi_hi 0 305a8000 1 1a 00008000 0 00000000 00000000 00000000
ori_reg 0 3499000f 1 19 0000f0ff 0 00000000 00000000 00000000
add_rr 0 00223020 1 06 0000011f 0 00000000 00000000 00000000
sub_rr 0 00233822 1 07 ffff8122 0 00000000 00000000 00000000
and_rr 0 00854024 1 08 00008020 0 00000000 00000000 00000000
or_rr 0 00664825 1 09 0000811f 0 00000000 00000000 00000000
slt_neg_lt 0 0041502a 1 0a 00000001 0 00000000 00000000 00000000
slt_pos_ge 0 0022582a 1 0b 00000000 0 00000000 00000000 00000000
funct_unknown 0 00219800 1 13 00000000 0 00000000 00000000 00000000
sw_word0 0 ac070010 0 00 00000000 1 00000010 ffff8122 00000000
sw_word1 0 ac090014 0 00 00000000 1 00000014 0000811f 00000000
lw_word0 0 8c0c0010 1 0c ffff8122 0 00000000 00000000 ffff8122
addi_base 0 200e0018 1 0e 00000018 0 00000000 00000000 00000000
lw_neg_off 0 8dcdfffc 1 0d 0000811f 0 00000000 00000000 0000811f
lw_wrap 0 8c0f0110 1 0f ffff8122 0 00000000 00000000 ffff8122
lw_empty 0 8c100020 1 10 00000000 0 00000000 00000000 00000000
op_beq 0 10220005 0 00 00000000 0 00000000 00000000 00000000
op_lui 0 3c01abcd 0 00 00000000 0 00000000 00000000 00000000
r1_intact 0 20310000 1 11 00000123 0 00000000 00000000 00000000
addi_r0 0 20000055 0 00 00000000 0 00000000 00000000 00000000
add_r0 0 00210020 0 00 00000000 0 00000000 00000000 00000000
r0_reads 0 00009025 1 12 00000000 0 00000000 00000000 00000000
b2b_addi 1 20140005 1 14 00000005 0 00000000 00000000 00000000
b2b_add 1 0294a820 1 15 0000000a 0 00000000 00000000 00000000
b2b_sw 1 ae950024 0 00 00000000 1 00000029 0000000a 00000000
b2b_lw 1 8c160028 1 16 0000000a 0 00000000 00000000 0000000a
b2b_sub 1 02d4b822 1 17 00000005 0 00000000 00000000 00000000
b2b_slt 0 02f5c02a 1 18 00000001 0 00000000 00000000 00000000

// ==== test/mipsCoreTb.sv ====
`timescale 1ns/1ps

module mipsCoreTb;

  localparam int clkPeriod = 8;
  localparam int caseMax = 64;
  localparam logic [31:0] lfsrSeed = 32'hcb9efdb0;

  logic         Clock;
  logic         rstN;
  logic [31:0]  instr;
  logic         instrValid;
  logic         regWe;
  logic [4:0]   regWAddr;
  logic [31:0]  regWData;
  logic         memWe;
  logic [31:0]  memAddr;
  logic [31:0]  memWData;
  logic [31:0]  readData;

  // expectation handed to the checker along with each strobe
  logic [127:0] expName;
  logic         expRegWe;
  logic [4:0]   expRegWAddr;
  logic [31:0]  expRegWData;
  logic         expMemWe;
  logic [31:0]  expMemAddr;
  logic [31:0]  expMemWData;
  logic [31:0]  expReadData;
  logic         runDone;
  int           checkedCount;
  int           failCount;

  // case table as read from the file
  logic [127:0] caseName [caseMax];
  logic         caseNoGap [caseMax];
  logic [31:0]  caseInstr [caseMax];
  logic         caseRegWe [caseMax];
  logic [4:0]   caseRegWAddr [caseMax];
  logic [31:0]  caseRegWData [caseMax];
  logic         caseMemWe [caseMax];
  logic [31:0]  caseMemAddr [caseMax];
  logic [31:0]  caseMemWData [caseMax];
  logic [31:0]  caseReadData [caseMax];
  int           caseCount;
  logic         loadError;
  logic         casesLoaded;
  logic [31:0]  lfsrState;
  int           gap;

  mipsCore UUT (
    .Clock      (Clock),
    .rstN       (rstN),
    .instr      (instr),
    .instrValid (instrValid),
    .regWe      (regWe),
    .regWAddr   (regWAddr),
    .regWData   (regWData),
    .memWe      (memWe),
    .memAddr    (memAddr),
    .memWData   (memWData),
    .readData   (readData)
  );

  resultChecker check (
    .Clock       (Clock),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .regWe       (regWe),
    .regWAddr    (regWAddr),
    .regWData    (regWData),
    .memWe       (memWe),
    .memAddr     (memAddr),
    .memWData    (memWData),
    .readData    (readData),
    .expName     (expName),
    .expRegWe    (expRegWe),
    .expRegWAddr (expRegWAddr),
    .expRegWData (expRegWData),
    .expMemWe    (expMemWe),
    .expMemAddr  (expMemAddr),
    .expMemWData (expMemWData),
    .expReadData (expReadData),
    .runDone     (runDone),
    .testCount   (checkedCount),
    .failCount   (failCount)
  );

  initial begin
    Clock = 1'b0;
    forever #(clkPeriod / 2) Clock = ~Clock;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    lfsrStep = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // idle cycles after a strobe, two LFSR bits
  task automatic drawGap(output int g);
    logic [1:0] bits;
    for (int b = 0; b < 2; b++) begin
      lfsrState = lfsrStep(lfsrState);
      bits[b] = lfsrState[0];
    end
    g = bits;
  endtask

  task automatic loadCases();
    int fd;
    int code;
    logic [8*160-1:0] lineBuf;
    logic [127:0] firstTok;
    fd = $fopen("test/mipsCases.txt", "r");
    if (fd == 0) begin
      $display("case file test/mipsCases.txt could not be opened");
      loadError = 1'b1;
    end else begin
      while (!loadError && $fgets(lineBuf, fd) > 0) begin
        code = $sscanf(lineBuf, "%s", firstTok);
        // blank lines and # lines carry no case
        if (code == 1 && firstTok != "#") begin
          if (caseCount == caseMax) begin
            $display("case file holds more than %0d cases", caseMax);
            loadError = 1'b1;
          end else begin
            code = $sscanf(lineBuf, "%s %h %h %h %h %h %h %h %h %h",
                           caseName[caseCount], caseNoGap[caseCount],
                           caseInstr[caseCount], caseRegWe[caseCount],
                           caseRegWAddr[caseCount], caseRegWData[caseCount],
                           caseMemWe[caseCount], caseMemAddr[caseCount],
                           caseMemWData[caseCount], caseReadData[caseCount]);
            if (code != 10) begin
              $display("case file line %0d has too few fields", caseCount + 1);
              loadError = 1'b1;
            end else begin
              caseCount++;
            end
          end
        end
      end
      $fclose(fd);
      if (!loadError && caseCount == 0) begin
        $display("case file holds no cases");
        loadError = 1'b1;
      end
    end
  endtask

  // present one case on the falling edge
  task automatic applyCase(input int n);
    instr       = caseInstr[n];
    instrValid  = 1'b1;
    expName     = caseName[n];
    expRegWe    = caseRegWe[n];
    expRegWAddr = caseRegWAddr[n];
    expRegWData = caseRegWData[n];
    expMemWe    = caseMemWe[n];
    expMemAddr  = caseMemAddr[n];
    expMemWData = caseMemWData[n];
    expReadData = caseReadData[n];
  endtask

  initial begin
    rstN        = 1'b0;
    instr       = 32'd0;
    instrValid  = 1'b0;
    expName     = '0;
    expRegWe    = 1'b0;
    expRegWAddr = 5'd0;
    expRegWData = 32'd0;
    expMemWe    = 1'b0;
    expMemAddr  = 32'd0;
    expMemWData = 32'd0;
    expReadData = 32'd0;
    runDone     = 1'b0;
    caseCount   = 0;
    loadError   = 1'b0;
    casesLoaded = 1'b0;
    lfsrState   = lfsrSeed;
    loadCases();
    if (loadError) begin
      $display("Simulation failed");
      $finish;
    end else begin
      casesLoaded = 1'b1;
      repeat (10) @(posedge Clock);
      @(negedge Clock);
      rstN = 1'b1;
      for (int i = 0; i < caseCount; i++) begin
        @(negedge Clock);
        applyCase(i);
        // chained cases strobe again inside the execute cycle
        if (caseNoGap[i]) begin
          gap = 0;
        end else begin
          drawGap(gap);
        end
        repeat (gap) begin
          @(negedge Clock);
          instrValid = 1'b0;
        end
      end
      @(negedge Clock);
      instrValid = 1'b0;
      repeat (2) @(negedge Clock);
      runDone = 1'b1;
      @(posedge Clock);
      if (checkedCount != caseCount) begin
        $display("only %0d of %0d cases reached the checker", checkedCount, caseCount);
      end
      if (failCount == 0 && checkedCount == caseCount) begin
        $display("Simulation completed successfully");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

  // worst case per test is one strobe plus three idle cycles
  initial begin
    wait (casesLoaded);
    repeat (4 * caseCount + 40) @(posedge Clock);
    $display("run timed out after %0d cycles", 4 * caseCount + 40);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== test/resultChecker.sv ====
`timescale 1ns/1ps

module resultChecker (
  input  logic         Clock,
  input  logic         rstN,
  input  logic         instrValid,
  input  logic         regWe,
  input  logic [4:0]   regWAddr,
  input  logic [31:0]  regWData,
  input  logic         memWe,
  input  logic [31:0]  memAddr,
  input  logic [31:0]  memWData,
  input  logic [31:0]  readData,
  input  logic [127:0] expName,
  input  logic         expRegWe,
  input  logic [4:0]   expRegWAddr,
  input  logic [31:0]  expRegWData,
  input  logic         expMemWe,
  input  logic [31:0]  expMemAddr,
  input  logic [31:0]  expMemWData,
  input  logic [31:0]  expReadData,
  input  logic         runDone,
  output int           testCount,
  output int           failCount
);

  // expectation for the instruction now in its execute cycle
  logic [127:0] curName;
  logic         curRegWe;
  logic [4:0]   curRegWAddr;
  logic [31:0]  curRegWData;
  logic         curMemWe;
  logic [31:0]  curMemAddr;
  logic [31:0]  curMemWData;
  logic [31:0]  curReadData;
  logic         armed;
  int           strayCount;

  initial begin
    testCount  = 0;
    failCount  = 0;
    strayCount = 0;
  end

  task automatic checkField(input string field, input logic [31:0] expVal,
                            input logic [31:0] actVal, inout int bad);
    if (actVal !== expVal) begin
      $display("[FAIL] %s %s expected %h actual %h", curName, field, expVal, actVal);
      bad++;
    end
  endtask

  task automatic compareResult();
    int bad;
    bad = 0;
    checkField("regWe", {31'd0, curRegWe}, {31'd0, regWe}, bad);
    checkField("memWe", {31'd0, curMemWe}, {31'd0, memWe}, bad);
    // address and data only mean something with their strobe
    if (curRegWe) begin
      checkField("regWAddr", {27'd0, curRegWAddr}, {27'd0, regWAddr}, bad);
      checkField("regWData", curRegWData, regWData, bad);
    end
    if (curMemWe) begin
      checkField("memAddr", curMemAddr, memAddr, bad);
      checkField("memWData", curMemWData, memWData, bad);
    end
    checkField("readData", curReadData, readData, bad);
    testCount++;
    if (bad == 0) begin
      $display("[PASS] %s", curName);
    end else begin
      failCount++;
    end
  endtask

  // a strobe seen on this edge makes the next cycle an execute cycle
  always @(posedge Clock) begin
    if (!rstN) begin
      armed <= 1'b0;
    end else begin
      armed <= instrValid;
      if (instrValid) begin
        curName     <= expName;
        curRegWe    <= expRegWe;
        curRegWAddr <= expRegWAddr;
        curRegWData <= expRegWData;
        curMemWe    <= expMemWe;
        curMemAddr  <= expMemAddr;
        curMemWData <= expMemWData;
        curReadData <= expReadData;
      end
    end
  end

  // mid-cycle sample, outputs settled and inputs not yet latched
  always @(negedge Clock) begin
    if (rstN && armed) begin
      compareResult();
    end else if (rstN && (regWe !== 1'b0 || memWe !== 1'b0)) begin
      $display("write strobe seen outside an execute cycle at %0t", $time);
      strayCount++;
      failCount++;
    end
  end

  always @(posedge runDone) begin
    $display("tests %0d  passed %0d  failed %0d  stray writes %0d",
             testCount, testCount - (failCount - strayCount), failCount - strayCount,
             strayCount);
  end

endmodule

// ==== verilog/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
  input  logic [1:0]  aluOp,
  input  logic [5:0]  funct,
  input  logic [15:0] imm16,
  input  logic        aluSrc,
  input  logic [31:0] rDataA,
  input  logic [31:0] rDataB,
  output logic [31:0] result
);

  // extended immediate
  logic [31:0] immExt;
  // second operand after the source mux
  logic [31:0] opB;
  // signed compare for slt
  logic        sltBit;

  // andi and ori take a zero-extended immediate
  // everything add-type sign-extends
  always_comb begin
    if ((aluOp == mipsPkg::aluOpAnd) || (aluOp == mipsPkg::aluOpOr)) begin
      immExt = {16'd0, imm16};
    end else begin
      immExt = {{16{imm16[15]}}, imm16};
    end
  end

  // register or immediate as operand B
  assign opB = aluSrc ? immExt : rDataB;

  assign sltBit = $signed(rDataA) < $signed(opB);

  always_comb begin
    case (aluOp)
      mipsPkg::aluOpAdd: begin
        // lw, sw address and addi
        result = rDataA + opB;
      end
      mipsPkg::aluOpAnd: begin
        result = rDataA & opB;
      end
      mipsPkg::aluOpOr: begin
        result = rDataA | opB;
      end
      default: begin
        // R-type, decode funct
        case (funct)
          mipsPkg::functAdd: result = rDataA + opB;
          mipsPkg::functSub: result = rDataA - opB;
          mipsPkg::functAnd: result = rDataA & opB;
          mipsPkg::functOr:  result = rDataA | opB;
          mipsPkg::functSlt: result = {31'd0, sltBit};
          // unknown funct yields zero
          default:           result = 32'd0;
        endcase
      end
    endcase
  end

endmodule

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
  input  logic [5:0] opcode,
  input  logic       execValid,
  output logic       regDst,
  output logic       aluSrc,
  output logic       memToReg,
  output logic       memWrite,
  output logic       memRead,
  output logic       regWrite,
  output logic [1:0] aluOp
);

  always_comb begin
    // all-zero default is also the idle decode outside execute
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    memWrite = 1'b0;
    memRead  = 1'b0;
    regWrite = 1'b0;
    aluOp    = mipsPkg::aluOpAdd;
    if (execValid) begin
      case (opcode)
        mipsPkg::opRType: begin
          // rd <= rs op rt
          regDst   = 1'b1;
          regWrite = 1'b1;
          aluOp    = mipsPkg::aluOpFunct;
        end
        mipsPkg::opLw: begin
          // rt <= mem[rs + simm]
          aluSrc   = 1'b1;
          memToReg = 1'b1;
          memRead  = 1'b1;
          regWrite = 1'b1;
          aluOp    = mipsPkg::aluOpAdd;
        end
        mipsPkg::opSw: begin
          // mem[rs + simm] <= rt with nothing written back
          aluSrc   = 1'b1;
          memToReg = 1'b0;
          memWrite = 1'b1;
          aluOp    = mipsPkg::aluOpAdd;
        end
        mipsPkg::opAddi: begin
          aluSrc   = 1'b1;
          regWrite = 1'b1;
          aluOp    = mipsPkg::aluOpAdd;
        end
        mipsPkg::opAndi: begin
          aluSrc   = 1'b1;
          regWrite = 1'b1;
          aluOp    = mipsPkg::aluOpAnd;
        end
        mipsPkg::opOri: begin
          aluSrc   = 1'b1;
          regWrite = 1'b1;
          aluOp    = mipsPkg::aluOpOr;
        end
        default: begin
          // unsupported opcode keeps the zero defaults and writes nothing
        end
      endcase
    end
  end

endmodule

// ==== verilog/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory (
  input  logic        Clock,
  input  logic        rstN,
  input  logic [31:0] addr,
  input  logic [31:0] wData,
  input  logic        memWrite,
  input  logic        memRead,
  input  logic        memToReg,
  input  logic [31:0] aluResult,
  output logic [31:0] readData,
  output logic [31:0] wbData
);

  // word storage
  logic [31:0] mem [mipsPkg::memWords];
  // word index, byte offset dropped
  // upper address bits are ignored so the address wraps at the depth
  logic [5:0]  wordIdx;

  assign wordIdx = addr[7:2];

  // store path, memory starts out all zero
  always_ff @(posedge Clock) begin
    if (!rstN) begin
      for (int k = 0; k < mipsPkg::memWords; k++) begin
        mem[k] <= 32'd0;
      end
    end else if (memWrite) begin
      mem[wordIdx] <= wData;
    end
  end

  // combinational load port, quiet when no load is active
  always_comb begin
    if (memRead) begin
      readData = mem[wordIdx];
    end else begin
      readData = 32'd0;
    end
  end

  // write-back select
  // loaded word for lw, ALU result for everything else
  always_comb begin
    if (memToReg) begin
      wbData = readData;
    end else begin
      wbData = aluResult;
    end
  end

endmodule

// ==== verilog/instrLatch.sv ====
`timescale 1ns/1ps

module instrLatch (
  input  logic              Clock,
  input  logic              rstN,
  input  mipsPkg::instrWord instr,
  input  logic              instrValid,
  output mipsPkg::instrWord execInstr,
  output logic              execValid
);

  // holding register for the word under execution
  mipsPkg::instrWord heldInstr;
  // high for the single execute cycle after a strobe
  logic heldValid;

  // instruction payload is only loaded on a strobe
  always_ff @(posedge Clock) begin
    if (instrValid) begin
      heldInstr <= instr;
    end
  end

  // execute flag follows the strobe by one cycle
  // a strobe during execute simply starts the next one
  always_ff @(posedge Clock) begin
    if (!rstN) begin
      heldValid <= 1'b0;
    end else begin
      heldValid <= instrValid;
    end
  end

  assign execInstr = heldInstr;
  assign execValid = heldValid;

endmodule

// ==== verilog/mipsCore.sv ====
`timescale 1ns/1ps

module mipsCore (
  input  logic              Clock,
  input  logic              rstN,
  input  mipsPkg::instrWord instr,
  input  logic              instrValid,
  output logic              regWe,
  output logic [4:0]        regWAddr,
  output logic [31:0]       regWData,
  output logic              memWe,
  output logic [31:0]       memAddr,
  output logic [31:0]       memWData,
  output logic [31:0]       readData
);

  // instruction under execution
  mipsPkg::instrWord execInstr;
  logic              execValid;

  // control lines
  logic       regDst;
  logic       aluSrc;
  logic       memToReg;
  logic       memWrite;
  logic       memRead;
  logic       regWrite;
  logic [1:0] aluOp;

  // datapath
  logic [31:0] rDataA;
  logic [31:0] rDataB;
  logic [31:0] aluResult;
  logic [31:0] wbData;
  logic [4:0]  destAddr;

  instrLatch uLatch (
    .Clock      (Clock),
    .rstN       (rstN),
    .instr      (instr),
    .instrValid (instrValid),
    .execInstr  (execInstr),
    .execValid  (execValid)
  );

  controlUnit uCtrl (
    .opcode    (execInstr.r.opcode),
    .execValid (execValid),
    .regDst    (regDst),
    .aluSrc    (aluSrc),
    .memToReg  (memToReg),
    .memWrite  (memWrite),
    .memRead   (memRead),
    .regWrite  (regWrite),
    .aluOp     (aluOp)
  );

  // rd for R-type, rt for the immediate forms
  assign destAddr = regDst ? execInstr.r.rd : execInstr.i.rt;

  regFile uRegs (
    .Clock  (Clock),
    .rstN   (rstN),
    .rAddrA (execInstr.r.rs),
    .rAddrB (execInstr.r.rt),
    .wAddr  (destAddr),
    .wEn    (regWrite),
    .wData  (wbData),
    .rDataA (rDataA),
    .rDataB (rDataB),
    .wDone  (regWe)
  );

  aluUnit uAlu (
    .aluOp  (aluOp),
    .funct  (execInstr.r.funct),
    .imm16  (execInstr.i.imm16),
    .aluSrc (aluSrc),
    .rDataA (rDataA),
    .rDataB (rDataB),
    .result (aluResult)
  );

  dataMemory uMem (
    .Clock     (Clock),
    .rstN      (rstN),
    .addr      (aluResult),
    .wData     (rDataB),
    .memWrite  (memWrite),
    .memRead   (memRead),
    .memToReg  (memToReg),
    .aluResult (aluResult),
    .readData  (readData),
    .wbData    (wbData)
  );

  // result ports
  assign regWAddr = destAddr;
  assign regWData = wbData;
  assign memWe    = memWrite;
  assign memAddr  = aluResult;
  assign memWData = rDataB;

endmodule

// ==== verilog/mipsPkg.sv ====
package mipsPkg;

  // main opcodes, instr[31:26]
  localparam logic [5:0] opRType = 6'b000000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opAddi  = 6'b001000;
  localparam logic [5:0] opAndi  = 6'b001100;
  localparam logic [5:0] opOri   = 6'b001101;

  // funct field of R-type, instr[5:0]
  localparam logic [5:0] functAdd = 6'b100000;
  localparam logic [5:0] functSub = 6'b100010;
  localparam logic [5:0] functAnd = 6'b100100;
  localparam logic [5:0] functOr  = 6'b100101;
  localparam logic [5:0] functSlt = 6'b101010;

  // ALUOp from the control unit
  // add covers lw, sw and addi
  localparam logic [1:0] aluOpAdd   = 2'b00;
  localparam logic [1:0] aluOpAnd   = 2'b01;
  // R-type, operation comes from funct
  localparam logic [1:0] aluOpFunct = 2'b10;
  localparam logic [1:0] aluOpOr    = 2'b11;

  // data memory depth in words
  localparam int memWords = 64;

  // one instruction word seen through both MIPS formats
  // opcode, rs and rt sit at the same bits in each view
  typedef union packed {
    // register format
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    // immediate format
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;
    } i;
  } instrWord;

endpackage

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic        Clock,
  input  logic        rstN,
  input  logic [4:0]  rAddrA,
  input  logic [4:0]  rAddrB,
  input  logic [4:0]  wAddr,
  input  logic        wEn,
  input  logic [31:0] wData,
  output logic [31:0] rDataA,
  output logic [31:0] rDataB,
  output logic        wDone
);

  // 32 general purpose registers
  logic [31:0] regs [32];

  // write only counts when it lands somewhere other than $zero
  assign wDone = wEn && (wAddr != 5'd0);

  // single write port, whole file cleared on reset
  always_ff @(posedge Clock) begin
    if (!rstN) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= 32'd0;
      end
    end else if (wDone) begin
      regs[wAddr] <= wData;
    end
  end

  // asynchronous read ports
  // $zero is hardwired regardless of array contents
  always_comb begin
    if (rAddrA == 5'd0) begin
      rDataA = 32'd0;
    end else begin
      rDataA = regs[rAddrA];
    end
  end

  always_comb begin
    if (rAddrB == 5'd0) begin
      rDataB = 32'd0;
    end else begin
      rDataB = regs[rAddrB];
    end
  end

endmodule
